// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = div_unit_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIMARGS   = +verilator+error+limit+1000
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/div_unit_props.sv ====
/*
 Divider core handshake properties
 bound into div_core, checks the ready pulse against busy and start
 */

`default_nettype none

module div_unit_props (
    input logic clk,
    input logic rst_n,
    input logic start_i,
    input logic busy_o,
    input logic ready_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    ready_pulse: assert property (@(posedge clk) disable iff (!rst_n) ready_o |=> !ready_o)
        else begin
            fail_cnt++;
            $error("ready_o stayed high for more than one cycle");
        end

    // result and busy never overlap
    ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n) ready_o |-> !busy_o)
        else begin
            fail_cnt++;
            $error("busy_o high in the same cycle as ready_o");
        end

    start_held: assert property (@(posedge clk) disable iff (!rst_n) busy_o |-> start_i)
        else begin
            fail_cnt++;
            $error("start_i dropped while the divider was busy");
        end

endmodule

bind div_core div_unit_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .busy_o  (busy_o),
    .ready_o (ready_o)
);

`default_nettype wire

// ==== bench/div_unit_tb.sv ====
/*
 Testbench for the integer divide unit
 random and corner divides, a queue-filling burst and non-divide
 words, all results checked in issue order against a reference model
 */

`default_nettype none

module div_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import div_unit_pkg::*;

    localparam int DEPTH    = 4;
    localparam int N_RANDOM = 24;
    localparam int N_REQS   = N_RANDOM + 10 + 1 + DEPTH;  // random, corners, busy, burst
    localparam logic [XLEN-1:0] MIN_INT = 32'h8000_0000;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            instr_valid_i;
    instr_u          instr_i;
    logic [XLEN-1:0] rs1_i;
    logic [XLEN-1:0] rs2_i;
    logic            full_o;
    logic            busy_o;
    logic            result_valid_o;
    div_result_t     result_o;

    div_result_t exp_q[$];  // expected results in issue order
    div_result_t exp_r;
    string       test_name = "reset";
    int          n_accepted = 0;
    int          n_results = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_tests = 0;
    int          test_err0 = 0;
    bit          saw_full = 1'b0;

    div_unit_top #(
        .FIFO_DEPTH (DEPTH)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .full_o         (full_o),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    always #20 clk = ~clk;

    // expected value from the M-extension rules
    function automatic logic [XLEN-1:0] ref_div(input logic [2:0] op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   ovf;
        sa  = a;
        sb  = b;
        ovf = (a == MIN_INT) && (b == '1);  // most negative over minus one
        case (op)
            DIVU:    return (b == '0) ? '1 : a / b;
            REMU:    return (b == '0) ? a : a % b;
            DIV:     return (b == '0) ? '1 : ovf ? a : $unsigned(sa / sb);
            default: return (b == '0) ? a : ovf ? '0 : $unsigned(sa % sb);
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
        n_checks++;
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            n_errors++;
        end
    endtask

    // one-cycle instruction strobe, queues the expected result if it is a divide
    task automatic issue(input logic [6:0] funct7, input logic [2:0] funct3,
                         input logic [6:0] opcode, input logic [4:0] rd,
                         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        div_result_t expected;
        instr_valid_i = 1'b1;
        instr_i.r     = '{funct7: funct7, rs2: 5'd2, rs1: 5'd1,
                          funct3: funct3, rd: rd, opcode: opcode};
        rs1_i         = a;
        rs2_i         = b;
        if (opcode == OPCODE_OP && funct7 == FUNCT7_MULDIV && funct3[2]) begin
            expected.rd    = rd;
            expected.value = ref_div(funct3, a, b);
            exp_q.push_back(expected);
            n_accepted++;
        end
        @(posedge clk);
        #2;
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_done();
        do @(posedge clk); while (n_results < n_accepted);
        #2;
    endtask

    task automatic divide_one(input logic [2:0] op, input logic [4:0] rd,
                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        issue(FUNCT7_MULDIV, op, OPCODE_OP, rd, a, b);
        wait_done();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("%-10s %s", test_name, (n_errors == test_err0) ? "ok" : "mismatch");
    endtask

    // scoreboard, full_o checked against the pending count before it drops
    always @(negedge clk) begin
        if (rst_n) begin
            if (full_o) begin
                saw_full = 1'b1;
                if (n_accepted - n_results != DEPTH) begin
                    $display("%s: full_o high with %0d requests pending", test_name,
                             n_accepted - n_results);
                    n_errors++;
                end
            end
            if (result_valid_o) begin
                n_results++;
                if (exp_q.size() == 0) begin
                    $display("%s: result for x%0d arrived with nothing outstanding",
                             test_name, result_o.rd);
                    n_errors++;
                end else begin
                    exp_r = exp_q.pop_front();
                    check_eq({test_name, " rd"}, XLEN'(exp_r.rd), XLEN'(result_o.rd));
                    check_eq({test_name, " value"}, exp_r.value, result_o.value);
                end
            end
        end
    end

    // every request may wait a full divide, plus reset and idle gaps
    initial begin
        #((N_REQS * 40 + 200) * 40);
        $display("timeout in %s: a divide result never arrived", test_name);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [2:0] op;
        int         props_fails;
        void'($urandom(32'h945d_2ee6));
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_i         = '0;
        rs2_i         = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        begin_test("reset");
        @(negedge clk);
        check_eq("reset flags", '0, {29'b0, result_valid_o, busy_o, full_o});
        @(posedge clk);
        #2;
        end_test();

        begin_test("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            op = 3'(4 + i % 4);  // DIV, DIVU, REM, REMU in turn
            divide_one(op, 5'($urandom), $urandom, $urandom >> (i % 31));
        end
        end_test();

        begin_test("corners");
        divide_one(DIV,  5'd1,  32'd1234,      '0);
        divide_one(DIVU, 5'd2,  32'hdead_beef, '0);
        divide_one(REM,  5'd3,  32'hffff_fff9, '0);
        divide_one(REMU, 5'd4,  32'h0000_0042, '0);
        divide_one(DIV,  5'd5,  MIN_INT,       '1);
        divide_one(REM,  5'd6,  MIN_INT,       '1);
        divide_one(DIV,  5'd7,  32'hffff_ffef, 32'd5);          // -17 / 5
        divide_one(REM,  5'd8,  32'hffff_ffef, 32'd5);
        divide_one(DIV,  5'd9,  32'd17,        32'hffff_fffb);  // 17 / -5
        divide_one(REM,  5'd10, 32'd17,        32'hffff_fffb);
        end_test();

        begin_test("busy");
        issue(FUNCT7_MULDIV, DIVU, OPCODE_OP, 5'd11, 32'd1000, 32'd7);
        @(negedge clk);
        while (!busy_o) @(negedge clk);
        while (!result_valid_o) begin
            if (!busy_o) begin
                $display("busy: busy_o dropped before the result came out");
                n_errors++;
            end
            @(negedge clk);
        end
        wait_done();
        end_test();

        begin_test("burst");
        saw_full = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            issue(FUNCT7_MULDIV, 3'(4 + i % 4), OPCODE_OP, 5'(20 + i), $urandom, $urandom >> 8);
        end
        wait_done();
        if (!saw_full) begin
            $display("burst: full_o never rose with %0d requests pending", DEPTH);
            n_errors++;
        end
        end_test();

        begin_test("non-divide");
        issue(FUNCT7_MULDIV, 3'b000, OPCODE_OP, 5'd12, $urandom, $urandom);  // MUL
        issue(7'b0100000, DIV, OPCODE_OP, 5'd13, $urandom, $urandom);        // SUB funct7
        issue(FUNCT7_MULDIV, DIV, 7'b0010011, 5'd14, $urandom, $urandom);    // OP-IMM
        repeat (50) @(posedge clk);
        #2;
        if (n_results != n_accepted) begin
            $display("non-divide: %0d results for %0d accepted instructions",
                     n_results, n_accepted);
            n_errors++;
        end
        end_test();

        props_fails = dut_i.u_core.u_props.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_tests, n_checks, n_errors, props_fails);
        if (n_errors == 0 && props_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/rv_isa_pkg.sv
source/div_unit_pkg.sv
source/div_issue.sv
source/div_req_fifo.sv
source/div_core.sv
source/div_unit_top.sv
bench/div_unit_props.sv
bench/div_unit_tb.sv

// ==== source/div_core.sv ====
/*
 Bit-serial restoring divider
 one-hot FSM idle/start/calc/end, 32 subtract-and-shift steps,
 signed fixup and the RISC-V divide-by-zero results
 */

`default_nettype none

module div_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  div_unit_pkg::div_req_t    req_i,
    output logic                      busy_o,
    output logic                      ready_o,
    output div_unit_pkg::div_result_t result_o
);

    import rv_isa_pkg::*;
    import div_unit_pkg::*;

    localparam logic [3:0] ST_IDLE  = 4'b0001;
    localparam logic [3:0] ST_START = 4'b0010;
    localparam logic [3:0] ST_CALC  = 4'b0100;
    localparam logic [3:0] ST_END   = 4'b1000;

    logic [3:0]      state;
    div_op_e         op_r;
    logic [4:0]      rd_r;
    logic [XLEN-1:0] quo_r;  // dividend shifts out, quotient shifts in
    logic [XLEN-1:0] rem_r;
    logic [XLEN-1:0] dvs_r;
    logic [XLEN-1:0] cnt_r;  // one-hot step countdown
    logic            neg_r;  // negate the final value

    logic            is_div;
    logic            is_signed;
    logic            dvs_zero;
    logic [XLEN:0]   partial;
    logic [XLEN:0]   diff;
    logic            ge;
    logic [XLEN-1:0] res_mag;

    assign is_div    = (op_r == DIV) || (op_r == DIVU);
    assign is_signed = (op_r == DIV) || (op_r == REM);
    assign dvs_zero  = (dvs_r == '0);

    // one restoring step with an extra bit so the compare stays unsigned
    assign partial = {rem_r, quo_r[XLEN-1]};
    assign diff    = partial - {1'b0, dvs_r};
    assign ge      = ~diff[XLEN];

    assign res_mag = is_div ? quo_r : rem_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            busy_o   <= 1'b0;
            ready_o  <= 1'b0;
            result_o <= '0;
        end else begin
            ready_o <= 1'b0;
            if (state != ST_IDLE && !start_i) begin
                // start dropped mid-operation so give up quietly
                state  <= ST_IDLE;
                busy_o <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (start_i && !ready_o) begin  // finished head still in place
                            state  <= ST_START;
                            busy_o <= 1'b1;
                        end
                    end
                    ST_START: begin
                        if (dvs_zero) begin
                            // all ones for div, dividend for rem
                            result_o.rd    <= rd_r;
                            result_o.value <= is_div ? '1 : quo_r;
                            ready_o        <= 1'b1;
                            busy_o         <= 1'b0;
                            state          <= ST_IDLE;
                        end else begin
                            state <= ST_CALC;
                        end
                    end
                    ST_CALC: begin
                        if (cnt_r[0]) state <= ST_END;  // last step
                    end
                    ST_END: begin
                        result_o.rd    <= rd_r;
                        result_o.value <= neg_r ? -res_mag : res_mag;
                        ready_o        <= 1'b1;
                        busy_o         <= 1'b0;
                        state          <= ST_IDLE;
                    end
                    default: begin
                        state  <= ST_IDLE;
                        busy_o <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (start_i && !ready_o) begin
                    op_r  <= div_op_e'(req_i.op);
                    rd_r  <= req_i.rd;
                    quo_r <= req_i.dividend;
                    dvs_r <= req_i.divisor;
                end
            end
            ST_START: begin
                rem_r <= '0;
                cnt_r <= {1'b1, {(XLEN-1){1'b0}}};
                // quotient sign from both operands, remainder follows dividend
                neg_r <= is_signed && (is_div ? (quo_r[XLEN-1] ^ dvs_r[XLEN-1])
                                              : quo_r[XLEN-1]);
                if (is_signed && quo_r[XLEN-1]) quo_r <= -quo_r;
                if (is_signed && dvs_r[XLEN-1]) dvs_r <= -dvs_r;
            end
            ST_CALC: begin
                rem_r <= ge ? diff[XLEN-1:0] : partial[XLEN-1:0];
                quo_r <= {quo_r[XLEN-2:0], ge};
                cnt_r <= {1'b0, cnt_r[XLEN-1:1]};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/div_issue.sv ====
/*
 Divide issue stage
 qualifies incoming instruction words as DIV/DIVU/REM/REMU and
 registers accepted ones as queue requests with a push strobe
 */

`default_nettype none

module div_issue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid_i,
    input  rv_isa_pkg::instr_u            instr_i,
    input  logic [div_unit_pkg::XLEN-1:0] rs1_i,
    input  logic [div_unit_pkg::XLEN-1:0] rs2_i,
    output logic                          push_o,
    output div_unit_pkg::div_req_t        req_o
);

    import rv_isa_pkg::*;
    import div_unit_pkg::*;

    logic accept;

    // funct3[2] separates the divide group from the multiplies
    assign accept = instr_valid_i
                 && (instr_i.r.opcode == OPCODE_OP)
                 && (instr_i.r.funct7 == FUNCT7_MULDIV)
                 && instr_i.r.funct3[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_o <= 1'b0;
        end else begin
            push_o <= accept;  // one cycle after the strobe
        end
    end

    // request payload, only loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req_o.op       <= instr_i.r.funct3;
            req_o.rd       <= instr_i.r.rd;
            req_o.dividend <= rs1_i;
            req_o.divisor  <= rs2_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/div_req_fifo.sv ====
/*
 Divide request queue
 circular buffer between issue and divider, head is the active request
 and stays put until the divider pops it
 */

`default_nettype none

module div_req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push_i,
    input  div_unit_pkg::div_req_t req_i,
    input  logic                   pop_i,
    output div_unit_pkg::div_req_t head_o,
    output logic                   not_empty_o,
    output logic                   full_o
);

    import div_unit_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    div_req_t    mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;  // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign not_empty_o = (wr_ptr != rd_ptr);
    assign full_o      = (wr_ptr[AW] != rd_ptr[AW])
                      && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push_i && !full_o;      // dropped when full
    assign do_pop  = pop_i && not_empty_o;

    assign head_o = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= req_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/div_unit_pkg.sv ====
/*
 Divide unit datapath definitions
 data width plus the request and result records passed between blocks
 */

`default_nettype none

package div_unit_pkg;

    localparam int XLEN = 32;

    // one queued divide request
    typedef struct packed {
        logic [2:0]      op;        // funct3 of the instruction
        logic [4:0]      rd;        // destination tag
        logic [XLEN-1:0] dividend;  // rs1 value
        logic [XLEN-1:0] divisor;   // rs2 value
    } div_req_t;

    // tagged result back to the core
    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
    } div_result_t;

endpackage

`default_nettype wire

// ==== source/div_unit_top.sv ====
/*
 Integer divide unit
 issue stage feeding a request queue drained in order by the
 serial divider core
 */

`default_nettype none

module div_unit_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid_i,
    input  rv_isa_pkg::instr_u            instr_i,
    input  logic [div_unit_pkg::XLEN-1:0] rs1_i,
    input  logic [div_unit_pkg::XLEN-1:0] rs2_i,
    output logic                          full_o,
    output logic                          busy_o,
    output logic                          result_valid_o,
    output div_unit_pkg::div_result_t     result_o
);

    import div_unit_pkg::*;

    logic     push;
    div_req_t issue_req;
    div_req_t head_req;
    logic     not_empty;  // doubles as the core start level

    div_issue u_issue (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .push_o        (push),
        .req_o         (issue_req)
    );

    div_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .req_i       (issue_req),
        .pop_i       (result_valid_o),  // core ready pops the head
        .head_o      (head_req),
        .not_empty_o (not_empty),
        .full_o      (full_o)
    );

    div_core u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (not_empty),
        .req_i    (head_req),
        .busy_o   (busy_o),
        .ready_o  (result_valid_o),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
/*
 RISC-V ISA definitions for the divide unit
 major opcode, M-extension funct7, divide funct3 codes and the
 R-type view of an instruction word
 */

`default_nettype none

package rv_isa_pkg;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;  // register-register ops
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension marker

    // funct3 of the divide group, bit 2 always set
    typedef enum logic [2:0] {
        DIV  = 3'b100,
        DIVU = 3'b101,
        REM  = 3'b110,
        REMU = 3'b111
    } div_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // same 32 bits seen as a plain word or as R-type fields
    typedef union packed {
        logic [31:0] raw;
        r_type_t     r;
    } instr_u;

endpackage

`default_nettype wire
